// ==== design/bus_ctrl_params.svh ====
// Bus control constants
// Bus widths, register map, reset values and identification words
`ifndef BUS_CTRL_PARAMS_SVH
`define BUS_CTRL_PARAMS_SVH

// -----------------------------------------------
// Bus widths
// -----------------------------------------------
`define SR_AWIDTH           8
`define RB_AWIDTH           8
`define BUS_DWIDTH          32
`define PHY_STATUS_W        16

// Settings register map
`define SR_LEDS_ADDR        8'd0
`define SR_SW_RST_ADDR      8'd1
`define SR_CLOCK_CTRL_ADDR  8'd2
`define SR_SFPP_CTRL0_ADDR  8'd8
`define SR_SFPP_CTRL1_ADDR  8'd9

// Readback word map
`define RB_COUNTER_ADDR       8'd0
`define RB_CLK_STATUS_ADDR    8'd3
`define RB_COMPAT_NUM_ADDR    8'd6
`define RB_NUM_CE_ADDR        8'd7
`define RB_SFPP_STATUS0_ADDR  8'd8
`define RB_SFPP_STATUS1_ADDR  8'd9

// GPS reference enabled out of reset
`define CLOCK_CTRL_RESET    8'h40

// -----------------------------------------------
// Identification
// -----------------------------------------------
`define COMPAT_MAJOR        16'h0021
`define COMPAT_MINOR        16'h0000
`define NUM_CE_VALUE        2

`endif

// ==== design/bus_ctrl_pkg.sv ====
// Bus control types
// Address enums and packed structs shared across the control block
`default_nettype none

`include "bus_ctrl_params.svh"

package bus_ctrl_pkg;

  // -----------------------------------------------
  // Address maps
  // -----------------------------------------------

  // Settings bus targets
  typedef enum logic [`SR_AWIDTH-1:0] {
    SR_LEDS       = `SR_LEDS_ADDR,
    SR_SW_RST     = `SR_SW_RST_ADDR,
    SR_CLOCK_CTRL = `SR_CLOCK_CTRL_ADDR,
    SR_SFPP_CTRL0 = `SR_SFPP_CTRL0_ADDR,
    SR_SFPP_CTRL1 = `SR_SFPP_CTRL1_ADDR
  } sr_addr_e;

  // Readback words
  typedef enum logic [`RB_AWIDTH-1:0] {
    RB_COUNTER      = `RB_COUNTER_ADDR,
    RB_CLK_STATUS   = `RB_CLK_STATUS_ADDR,
    RB_COMPAT_NUM   = `RB_COMPAT_NUM_ADDR,
    RB_NUM_CE       = `RB_NUM_CE_ADDR,
    RB_SFPP_STATUS0 = `RB_SFPP_STATUS0_ADDR,
    RB_SFPP_STATUS1 = `RB_SFPP_STATUS1_ADDR
  } rb_addr_e;

  // -----------------------------------------------
  // Bus transfers
  // -----------------------------------------------

  // One settings write, valid for the cycle stb is high
  typedef struct packed {
    logic                   stb;
    sr_addr_e               addr;
    logic [`BUS_DWIDTH-1:0] data;
  } set_bus_t;

  // One readback request
  typedef struct packed {
    logic     rd_stb;
    rb_addr_e addr;
  } rb_req_t;

  // -----------------------------------------------
  // SFP+ cage status
  // -----------------------------------------------

  // Low speed cage pins
  typedef struct packed {
    logic mod_abs;
    logic tx_fault;
    logic rx_los;
  } sfpp_pins_t;

  // Status word, top bit first
  typedef struct packed {
    logic [`PHY_STATUS_W-1:0] phy_status;
    logic [9:0]               pad;
    sfpp_pins_t               changed;
    sfpp_pins_t               level;
  } sfpp_status_t;

endpackage

`default_nettype wire

// ==== design/ctrl_settings.sv ====
// Control settings register file
// Decodes settings bus writes into LED, soft reset, clock and SFP+ rate outputs
`timescale 1ns/100ps
`default_nettype none

`include "bus_ctrl_params.svh"

module ctrl_settings (
  input  wire                        clk,
  input  wire                        i_rst_n,
  // Settings bus
  input  wire bus_ctrl_pkg::set_bus_t i_set,
  // Front panel LEDs
  output logic [7:0]                 o_leds,
  // Soft resets
  output logic [3:0]                 o_sw_rst,
  // Clock source and reference control
  output logic [7:0]                 o_clock_control,
  // SFP+ rate select, 1 pulls the pin low
  output logic [1:0]                 o_sfpp0_rs_drive,
  output logic [1:0]                 o_sfpp1_rs_drive
);

  import bus_ctrl_pkg::*;

  // -----------------------------------------------
  // Write data slices
  // -----------------------------------------------

  // Each register takes the low bits of the word
  logic [7:0] wr_byte;
  logic [3:0] wr_nibble;
  logic [1:0] wr_pair;

  assign wr_byte   = i_set.data[7:0];
  assign wr_nibble = i_set.data[3:0];
  assign wr_pair   = i_set.data[1:0];

  // -----------------------------------------------
  // Register bank
  // -----------------------------------------------

  // Soft reset bits
  //   bit 0 holds the PHY in reset
  //   bit 1 resets the radio clock domain
  //   bit 2 resets the radio clock PLL
  //   bit 3 resets the ADC delay controller
  //
  // Clock control bit 6 enables the GPS reference,
  // so it comes out of reset set
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_leds           <= '0;
      o_sw_rst         <= '0;
      o_clock_control  <= `CLOCK_CTRL_RESET;
      o_sfpp0_rs_drive <= '0;
      o_sfpp1_rs_drive <= '0;
    end else if (i_set.stb) begin
      // Address decode, other addresses are ignored
      case (i_set.addr)
        SR_LEDS: begin
          o_leds <= wr_byte;
        end
        SR_SW_RST: begin
          o_sw_rst <= wr_nibble;
        end
        SR_CLOCK_CTRL: begin
          o_clock_control <= wr_byte;
        end
        // Cage 0 RS0 in bit 0, RS1 in bit 1
        SR_SFPP_CTRL0: begin
          o_sfpp0_rs_drive <= wr_pair;
        end
        // Cage 1 uses the same layout
        SR_SFPP_CTRL1: begin
          o_sfpp1_rs_drive <= wr_pair;
        end
        default: begin
          // No register here
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/sfpp_status_monitor.sv ====
// SFP+ cage status monitor
// Synchronizes cage pins and PHY status, latches pin changes until read
`timescale 1ns/100ps
`default_nettype none

`include "bus_ctrl_params.svh"

module sfpp_status_monitor (
  input  wire                             clk,
  input  wire                             i_rst_n,
  // Asynchronous cage pins
  input  wire bus_ctrl_pkg::sfpp_pins_t   i_pins,
  // Asynchronous PHY status bits
  input  wire [`PHY_STATUS_W-1:0]         i_phy_status,
  // Clear of the change flags on a status read
  input  wire                             i_clear,
  output bus_ctrl_pkg::sfpp_status_t      o_status
);

  import bus_ctrl_pkg::*;

  // -----------------------------------------------
  // Synchronizers
  // -----------------------------------------------

  sfpp_pins_t               pins_meta;
  sfpp_pins_t               pins_sync;
  sfpp_pins_t               pins_prev;
  sfpp_pins_t               pins_toggle;
  sfpp_pins_t               pins_changed;
  logic [`PHY_STATUS_W-1:0] phy_meta;
  logic [`PHY_STATUS_W-1:0] phy_sync;

  // Two flops per bit, every bit treated as independent
  always_ff @(posedge clk) begin
    pins_meta <= i_pins;
    pins_sync <= pins_meta;
    phy_meta  <= i_phy_status;
    phy_sync  <= phy_meta;
  end

  // Last synchronized level for edge detect
  always_ff @(posedge clk) begin
    pins_prev <= pins_sync;
  end

  // Any edge on any pin
  assign pins_toggle = pins_sync ^ pins_prev;

  // -----------------------------------------------
  // Change latches
  // -----------------------------------------------

  // Sticky until cleared
  // a new edge during the clear cycle wins
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      pins_changed <= '0;
    end else if (i_clear) begin
      pins_changed <= pins_toggle;
    end else begin
      pins_changed <= pins_changed | pins_toggle;
    end
  end

  // Status word
  always_comb begin
    o_status            = '0;
    o_status.phy_status = phy_sync;
    o_status.changed    = pins_changed;
    o_status.level      = pins_sync;
  end

endmodule

`default_nettype wire

// ==== design/readback_mux.sv ====
// Readback word selector
// Registered status readback, free-running cycle counter and cage flag clears
`timescale 1ns/100ps
`default_nettype none

`include "bus_ctrl_params.svh"

module readback_mux (
  input  wire                              clk,
  input  wire                              i_rst_n,
  // Readback request
  input  wire bus_ctrl_pkg::rb_req_t       i_rb,
  // Clock chip status pins
  input  wire [7:0]                        i_clock_status,
  // Cage status words
  input  wire bus_ctrl_pkg::sfpp_status_t  i_sfpp0_status,
  input  wire bus_ctrl_pkg::sfpp_status_t  i_sfpp1_status,
  // Flag clears back to the cage monitors
  output logic                             o_sfpp0_clear,
  output logic                             o_sfpp1_clear,
  // Readback response
  output logic [`BUS_DWIDTH-1:0]           o_rb_data,
  output logic                             o_rb_valid
);

  import bus_ctrl_pkg::*;

  // Fixed identification words
  localparam logic [`BUS_DWIDTH-1:0] COMPAT_WORD = {`COMPAT_MAJOR, `COMPAT_MINOR};
  localparam logic [`BUS_DWIDTH-1:0] NUM_CE_WORD = `NUM_CE_VALUE;

  logic [`BUS_DWIDTH-1:0] counter;
  logic [`BUS_DWIDTH-1:0] rb_sel;

  // -----------------------------------------------
  // Cycle counter
  // -----------------------------------------------

  // Wraps silently
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      counter <= '0;
    end else begin
      counter <= counter + 1'b1;
    end
  end

  // -----------------------------------------------
  // Word select
  // -----------------------------------------------

  always_comb begin
    case (i_rb.addr)
      RB_COUNTER:      rb_sel = counter;
      RB_CLK_STATUS:   rb_sel = {{(`BUS_DWIDTH-8){1'b0}}, i_clock_status};
      RB_COMPAT_NUM:   rb_sel = COMPAT_WORD;
      RB_NUM_CE:       rb_sel = NUM_CE_WORD;
      // Flags as they stood before this read clears them
      RB_SFPP_STATUS0: rb_sel = i_sfpp0_status;
      RB_SFPP_STATUS1: rb_sel = i_sfpp1_status;
      default:         rb_sel = '0;
    endcase
  end

  // Clear pulses, same cycle as the read strobe
  assign o_sfpp0_clear = i_rb.rd_stb && (i_rb.addr == RB_SFPP_STATUS0);
  assign o_sfpp1_clear = i_rb.rd_stb && (i_rb.addr == RB_SFPP_STATUS1);

  // -----------------------------------------------
  // Response registers
  // -----------------------------------------------

  // One valid pulse per strobe
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_rb_valid <= 1'b0;
    end else begin
      o_rb_valid <= i_rb.rd_stb;
    end
  end

  // Data holds until the next read
  always_ff @(posedge clk) begin
    if (i_rb.rd_stb) begin
      o_rb_data <= rb_sel;
    end
  end

endmodule

`default_nettype wire

// ==== design/bus_ctrl_top.sv ====
// Bus control block top level
// Settings register file and two SFP+ cage monitors feeding the readback mux
`timescale 1ns/100ps
`default_nettype none

`include "bus_ctrl_params.svh"

module bus_ctrl_top (
  input  wire                             clk,
  input  wire                             i_rst_n,
  // Settings and readback buses
  input  wire bus_ctrl_pkg::set_bus_t     i_set,
  input  wire bus_ctrl_pkg::rb_req_t      i_rb,
  // Clock chip status
  input  wire [7:0]                       i_clock_status,
  // SFP+ cage pins and PHY status
  input  wire bus_ctrl_pkg::sfpp_pins_t   i_sfpp0_pins,
  input  wire bus_ctrl_pkg::sfpp_pins_t   i_sfpp1_pins,
  input  wire [`PHY_STATUS_W-1:0]         i_sfpp0_phy_status,
  input  wire [`PHY_STATUS_W-1:0]         i_sfpp1_phy_status,
  // Control outputs
  output wire [7:0]                       o_leds,
  output wire [3:0]                       o_sw_rst,
  output wire [7:0]                       o_clock_control,
  // Rate pin pull-down enables, pads live outside
  output wire [1:0]                       o_sfpp0_rs_drive,
  output wire [1:0]                       o_sfpp1_rs_drive,
  // Readback response
  output wire [`BUS_DWIDTH-1:0]           o_rb_data,
  output wire                             o_rb_valid
);

  import bus_ctrl_pkg::*;

  // Cage monitor to readback mux
  sfpp_status_t sfpp0_status;
  sfpp_status_t sfpp1_status;
  wire          sfpp0_clear;
  wire          sfpp1_clear;

  // -----------------------------------------------
  // Settings
  // -----------------------------------------------

  ctrl_settings u_settings (
    .clk              (clk),
    .i_rst_n          (i_rst_n),
    .i_set            (i_set),
    .o_leds           (o_leds),
    .o_sw_rst         (o_sw_rst),
    .o_clock_control  (o_clock_control),
    .o_sfpp0_rs_drive (o_sfpp0_rs_drive),
    .o_sfpp1_rs_drive (o_sfpp1_rs_drive)
  );

  // -----------------------------------------------
  // Cage monitors
  // -----------------------------------------------

  sfpp_status_monitor u_sfpp0_mon (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_pins       (i_sfpp0_pins),
    .i_phy_status (i_sfpp0_phy_status),
    .i_clear      (sfpp0_clear),
    .o_status     (sfpp0_status)
  );

  sfpp_status_monitor u_sfpp1_mon (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_pins       (i_sfpp1_pins),
    .i_phy_status (i_sfpp1_phy_status),
    .i_clear      (sfpp1_clear),
    .o_status     (sfpp1_status)
  );

  // -----------------------------------------------
  // Readback
  // -----------------------------------------------

  readback_mux u_readback (
    .clk            (clk),
    .i_rst_n        (i_rst_n),
    .i_rb           (i_rb),
    .i_clock_status (i_clock_status),
    .i_sfpp0_status (sfpp0_status),
    .i_sfpp1_status (sfpp1_status),
    .o_sfpp0_clear  (sfpp0_clear),
    .o_sfpp1_clear  (sfpp1_clear),
    .o_rb_data      (o_rb_data),
    .o_rb_valid     (o_rb_valid)
  );

endmodule

`default_nettype wire

// ==== tests/bus_ctrl_properties.sv ====
// Bus control assertions
// Reset state, readback valid timing and soft reset write rules
`timescale 1ns/100ps
`default_nettype none

`include "bus_ctrl_params.svh"

module bus_ctrl_properties (
  input wire                          clk,
  input wire                          i_rst_n,
  input wire bus_ctrl_pkg::set_bus_t  i_set,
  input wire bus_ctrl_pkg::rb_req_t   i_rb,
  input wire [3:0]                    o_sw_rst,
  input wire [7:0]                    o_clock_control,
  input wire                          o_rb_valid
);

  import bus_ctrl_pkg::*;

  // Number of assertion failures so far
  int fail_count;

  // -----------------------------------------------
  // Readback valid follows each strobe by one cycle
  // -----------------------------------------------
  assert property (@(posedge clk) disable iff (!i_rst_n) i_rb.rd_stb |=> o_rb_valid)
    else begin
      $error("Readback valid missing one cycle after a read strobe");
      fail_count++;
    end
  assert property (@(posedge clk) disable iff (!i_rst_n) !i_rb.rd_stb |=> !o_rb_valid)
    else begin
      $error("Readback valid without a read strobe");
      fail_count++;
    end

  // Reset state held while reset is low
  assert property (@(posedge clk)
    !i_rst_n |-> (!o_rb_valid && o_clock_control == `CLOCK_CTRL_RESET))
    else begin
      $error("Readback valid or clock control wrong during reset");
      fail_count++;
    end

  // Soft reset moves only after a write to its address
  assert property (@(posedge clk) disable iff (!i_rst_n)
    (o_sw_rst != $past(o_sw_rst)) |-> $past(i_set.stb && i_set.addr == SR_SW_RST))
    else begin
      $error("Soft reset output changed without a write");
      fail_count++;
    end

endmodule

bind bus_ctrl_top bus_ctrl_properties u_props (
  .clk             (clk),
  .i_rst_n         (i_rst_n),
  .i_set           (i_set),
  .i_rb            (i_rb),
  .o_sw_rst        (o_sw_rst),
  .o_clock_control (o_clock_control),
  .o_rb_valid      (o_rb_valid)
);

`default_nettype wire

// ==== tests/bus_ctrl_tb.sv ====
// Bus control testbench
// Directed tests of settings writes, readback words and SFP+ change latching
`timescale 1ns/100ps
`default_nettype none

`include "bus_ctrl_params.svh"

module bus_ctrl_tb;

  import bus_ctrl_pkg::*;

  localparam int  CLK_PERIOD   = 20;
  localparam int  RESET_CYCLES = 8;
  localparam time DRIVE_DELAY  = 2;
  localparam int  RB_TIMEOUT   = 10;
  // Roughly 40 cycles per test run, six runs, plus reset
  localparam int  TEST_CYCLES  = RESET_CYCLES + 6 * 40;
  localparam int  WATCHDOG_CYCLES = TEST_CYCLES + 100;
  localparam logic [31:0] SEED = 32'hadec_45e9;

  logic         clk;
  logic         i_rst_n;
  set_bus_t     set_bus;
  rb_req_t      rb_req;
  logic [7:0]   clock_status;
  sfpp_pins_t   sfpp0_pins;
  sfpp_pins_t   sfpp1_pins;
  logic [15:0]  sfpp0_phy;
  logic [15:0]  sfpp1_phy;
  wire  [7:0]   o_leds;
  wire  [3:0]   o_sw_rst;
  wire  [7:0]   o_clock_control;
  wire  [1:0]   o_sfpp0_rs_drive;
  wire  [1:0]   o_sfpp1_rs_drive;
  wire  [31:0]  o_rb_data;
  wire          o_rb_valid;

  // Expected register state
  logic [7:0]   exp_leds;
  logic [3:0]   exp_sw_rst;
  logic [7:0]   exp_clock_ctrl;
  logic [1:0]   exp_rs0;
  logic [1:0]   exp_rs1;
  // Pin and PHY state last applied per cage
  logic [2:0]   cage_pins [2];
  logic [15:0]  cage_phy [2];

  bus_ctrl_top DUT (
    .clk                (clk),
    .i_rst_n            (i_rst_n),
    .i_set              (set_bus),
    .i_rb               (rb_req),
    .i_clock_status     (clock_status),
    .i_sfpp0_pins       (sfpp0_pins),
    .i_sfpp1_pins       (sfpp1_pins),
    .i_sfpp0_phy_status (sfpp0_phy),
    .i_sfpp1_phy_status (sfpp1_phy),
    .o_leds             (o_leds),
    .o_sw_rst           (o_sw_rst),
    .o_clock_control    (o_clock_control),
    .o_sfpp0_rs_drive   (o_sfpp0_rs_drive),
    .o_sfpp1_rs_drive   (o_sfpp1_rs_drive),
    .o_rb_data          (o_rb_data),
    .o_rb_valid         (o_rb_valid)
  );

  // --------------------------------------------------
  // Clock and watchdog
  // --------------------------------------------------
  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    report_failure("Timeout: tests did not finish within the watchdog limit");
  end

  // Bound assertion failures stop the run too
  always @(DUT.u_props.fail_count) begin
    if (DUT.u_props.fail_count != 0) begin
      report_failure("A bound assertion failed, see the error above");
    end
  end

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  task automatic report_failure(input string reason);
    $display("%s", reason);
    $display("Test failures found");
    $fatal(1, "Stopping at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      report_failure($sformatf("Error at %0d ns: %s is 0x%08h, expected 0x%08h",
                               $time, name, actual, expected));
    end
  endtask

  // Next drive point, just after the rising edge
  task automatic step_clock();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
    step_clock();
    set_bus.stb  = 1'b1;
    set_bus.addr = sr_addr_e'(addr);
    set_bus.data = data;
    step_clock();
    set_bus.stb  = 1'b0;
  endtask

  task automatic read_word(input logic [7:0] addr, output logic [31:0] data);
    int wait_cycles;
    step_clock();
    rb_req.rd_stb = 1'b1;
    rb_req.addr   = rb_addr_e'(addr);
    step_clock();
    rb_req.rd_stb = 1'b0;
    wait_cycles = 0;
    while (o_rb_valid !== 1'b1 && wait_cycles < RB_TIMEOUT) begin
      step_clock();
      wait_cycles++;
    end
    if (o_rb_valid !== 1'b1) begin
      report_failure("Readback valid never arrived after a read strobe");
    end else begin
      data = o_rb_data;
    end
  endtask

  task automatic check_outputs();
    check_value("o_leds", o_leds, exp_leds);
    check_value("o_sw_rst", o_sw_rst, exp_sw_rst);
    check_value("o_clock_control", o_clock_control, exp_clock_ctrl);
    check_value("o_sfpp0_rs_drive", o_sfpp0_rs_drive, exp_rs0);
    check_value("o_sfpp1_rs_drive", o_sfpp1_rs_drive, exp_rs1);
  endtask

  // Status layout: PHY on top, zero pad, changed flags, levels
  function automatic logic [31:0] status_word(input logic [15:0] phy,
                                              input logic [2:0] changed,
                                              input logic [2:0] level);
    status_word = {phy, 10'b0, changed, level};
  endfunction

  task automatic drive_cage(input int cage, input logic [2:0] pins, input logic [15:0] phy);
    cage_pins[cage] = pins;
    cage_phy[cage]  = phy;
    if (cage == 0) begin
      sfpp0_pins = pins;
      sfpp0_phy  = phy;
    end else begin
      sfpp1_pins = pins;
      sfpp1_phy  = phy;
    end
  endtask

  // --------------------------------------------------
  // Directed tests
  // --------------------------------------------------
  task automatic test_reset_values();
    logic [31:0] data;
    check_outputs();
    read_word(`RB_COMPAT_NUM_ADDR, data);
    check_value("compat word", data, 32'h0021_0000);
    read_word(`RB_NUM_CE_ADDR, data);
    check_value("engine count", data, 32'd2);
    // Pins low and no change flags out of reset
    read_word(`RB_SFPP_STATUS0_ADDR, data);
    check_value("cage 0 status", data, 32'h0);
    read_word(`RB_SFPP_STATUS1_ADDR, data);
    check_value("cage 1 status", data, 32'h0);
  endtask

  task automatic test_settings_writes();
    logic [7:0]  addrs [5];
    logic [31:0] data;
    addrs = '{`SR_LEDS_ADDR, `SR_SW_RST_ADDR, `SR_CLOCK_CTRL_ADDR,
              `SR_SFPP_CTRL0_ADDR, `SR_SFPP_CTRL1_ADDR};
    foreach (addrs[i]) begin
      data = $urandom();
      write_setting(addrs[i], data);
      case (addrs[i])
        `SR_LEDS_ADDR:       exp_leds = data[7:0];
        `SR_SW_RST_ADDR:     exp_sw_rst = data[3:0];
        `SR_CLOCK_CTRL_ADDR: exp_clock_ctrl = data[7:0];
        `SR_SFPP_CTRL0_ADDR: exp_rs0 = data[1:0];
        default:             exp_rs1 = data[1:0];
      endcase
      check_outputs();
    end
    // Unused address leaves everything alone
    write_setting(8'd5, $urandom());
    check_outputs();
  endtask

  task automatic test_readback_values();
    logic [31:0] first;
    logic [31:0] second;
    int          gap;
    clock_status = $urandom_range(255, 0);
    read_word(`RB_CLK_STATUS_ADDR, first);
    check_value("clock status", first, {24'h0, clock_status});
    read_word(8'd5, first);
    check_value("unmapped word", first, 32'h0);
    // Back to back reads are 2 cycles apart, idle cycles add to that
    gap = 2 + $urandom_range(15, 0);
    read_word(`RB_COUNTER_ADDR, first);
    repeat (gap - 2) step_clock();
    read_word(`RB_COUNTER_ADDR, second);
    check_value("counter delta", second - first, gap);
  endtask

  task automatic test_cage_latching(input int cage);
    logic [7:0]  addr;
    logic [2:0]  old_pins;
    logic [2:0]  new_pins;
    logic [15:0] phy;
    logic [31:0] data;
    addr = (cage == 0) ? `RB_SFPP_STATUS0_ADDR : `RB_SFPP_STATUS1_ADDR;
    repeat (2) begin
      old_pins = cage_pins[cage];
      new_pins = $urandom_range(7, 0);
      phy      = $urandom_range(16'hffff, 0);
      drive_cage(cage, new_pins, phy);
      repeat (6) step_clock();
      read_word(addr, data);
      check_value("cage status", data, status_word(phy, old_pins ^ new_pins, new_pins));
      // Flags gone after the read
      read_word(addr, data);
      check_value("cage status after clear", data, status_word(phy, 3'b000, new_pins));
    end
  endtask

  task automatic test_cage_independence();
    logic [2:0]  mask;
    logic [2:0]  new_pins;
    logic [31:0] data;
    mask     = $urandom_range(7, 1);
    new_pins = cage_pins[1] ^ mask;
    drive_cage(1, new_pins, cage_phy[1]);
    repeat (6) step_clock();
    read_word(`RB_SFPP_STATUS0_ADDR, data);
    check_value("cage 0 status", data, status_word(cage_phy[0], 3'b000, cage_pins[0]));
    read_word(`RB_SFPP_STATUS1_ADDR, data);
    check_value("cage 1 status", data, status_word(cage_phy[1], mask, new_pins));
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    void'($urandom(SEED));
    i_rst_n        = 1'b1;
    set_bus        = '0;
    rb_req         = '0;
    clock_status   = '0;
    sfpp0_pins     = '0;
    sfpp1_pins     = '0;
    sfpp0_phy      = '0;
    sfpp1_phy      = '0;
    exp_leds       = '0;
    exp_sw_rst     = '0;
    exp_clock_ctrl = 8'h40;
    exp_rs0        = '0;
    exp_rs1        = '0;
    cage_pins      = '{3'b000, 3'b000};
    cage_phy       = '{16'h0, 16'h0};
    #1 i_rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY i_rst_n = 1'b1;
    step_clock();

    test_reset_values();
    test_settings_writes();
    test_readback_values();
    test_cage_latching(0);
    test_cage_latching(1);
    test_cage_independence();

    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+design
design/bus_ctrl_pkg.sv
design/ctrl_settings.sv
design/sfpp_status_monitor.sv
design/readback_mux.sv
design/bus_ctrl_top.sv
tests/bus_ctrl_properties.sv
tests/bus_ctrl_tb.sv
